// ==== spatz_dec_macros.svh ====
/*
 * Encodings for the vector instruction decoder: major opcodes, func3
 * codes of the vector opcode and the vector CSR addresses.
 */
`ifndef SPATZ_DEC_MACROS_SVH
`define SPATZ_DEC_MACROS_SVH

`define ELEN 32

// Major opcodes
`define OPC_LOAD_FP  7'b0000111
`define OPC_STORE_FP 7'b0100111
`define OPC_VEC      7'b1010111
`define OPC_SYSTEM   7'b1110011

// func3 of OP-V
`define F3_OPIVV 3'b000
`define F3_OPMVV 3'b010
`define F3_OPIVI 3'b011
`define F3_OPIVX 3'b100
`define F3_OPMVX 3'b110
`define F3_OPCFG 3'b111

`define CSR_VSTART 12'h008
`define CSR_VXSAT  12'h009
`define CSR_VXRM   12'h00A
`define CSR_VCSR   12'h00F
`define CSR_VL     12'hC20
`define CSR_VTYPE  12'hC21
`define CSR_VLENB  12'hC22

`endif

// ==== spatz_dec_pkg.sv ====
/*
 * Types shared by the decoder modules: operation, unit and element width,
 * the vtype layout and the two views of one instruction word.
 */
`default_nettype none

`include "spatz_dec_macros.svh"

package spatz_dec_pkg;

  typedef logic [`ELEN-1:0] elen_t;

  typedef enum logic [4:0] {
    NOP,
    VLE,
    VLSE,
    VSE,
    VSSE,
    VCFG,
    VCSR,
    VADD,
    VSUB,
    VRSUB,
    VAND,
    VOR,
    VXOR,
    VSLL,
    VSRL,
    VSRA,
    VMIN,
    VMINU,
    VMAX,
    VMAXU
  } op_e;

  typedef enum logic [1:0] {CON, VFU, LSU} ex_unit_e;

  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vew_e;

  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // OP-V and config fields, or load/store and CSR fields
  typedef union packed {
    struct packed {
      logic [5:0] funct6;
      logic       vm;
      logic [4:0] vs2;
      logic [4:0] vs1;
      logic [2:0] funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
    } arith;
    struct packed {
      logic [2:0] nf;
      logic       mew;
      logic [1:0] mop;
      logic       vm;
      logic [4:0] lumop;
      logic [4:0] rs1;
      logic [2:0] width;
      logic [4:0] rd;
      logic [6:0] opcode;
    } mem;
  } instr_u;

endpackage

`default_nettype wire

// ==== spatz_mem_decoder.sv ====
/*
 * Vector load and store decoding. Combinational, selected by the top
 * for the load-FP and store-FP opcodes.
 */
`timescale 1ns/1ps
`default_nettype none

module spatz_mem_decoder (
  input  spatz_dec_pkg::instr_u instr_i,
  input  spatz_dec_pkg::elen_t  rs1_i,
  input  spatz_dec_pkg::elen_t  rs2_i,
  input  logic                  rs1_valid_i,
  output spatz_dec_pkg::op_e    op_o,
  output spatz_dec_pkg::vew_e   vsew_o,
  output logic [4:0]            vd_o,
  output logic                  use_vd_o,
  output logic                  vd_is_src_o,
  output logic                  vm_o,
  output spatz_dec_pkg::elen_t  rs1_o,
  output spatz_dec_pkg::elen_t  rs2_o,
  output logic                  illegal_o
);

  import spatz_dec_pkg::*;

  logic is_store;
  logic strided;
  logic width_ok;
  logic mop_ok;

  // Store opcode differs from load only in bit 5
  assign is_store    = instr_i.mem.opcode[5];
  assign vd_o        = instr_i.mem.rd;
  assign use_vd_o    = 1'b1;
  assign vd_is_src_o = is_store;
  assign vm_o        = instr_i.mem.vm;
  assign rs1_o       = rs1_i;
  assign rs2_o       = strided ? rs2_i : '0;

  always_comb begin
    width_ok = 1'b1;
    vsew_o   = EW_8;
    unique case ({instr_i.mem.mew, instr_i.mem.width})
      4'b0000: vsew_o = EW_8;
      4'b0101: vsew_o = EW_16;
      4'b0110: vsew_o = EW_32;
      default: width_ok = 1'b0;
    endcase
  end

  always_comb begin
    strided = 1'b0;
    mop_ok  = 1'b1;
    unique case (instr_i.mem.mop)
      2'b00:   mop_ok = instr_i.mem.lumop == 5'd0;
      2'b10:   strided = 1'b1;
      default: mop_ok = 1'b0;
    endcase
    unique case ({is_store, strided})
      2'b00:   op_o = VLE;
      2'b01:   op_o = VLSE;
      2'b10:   op_o = VSE;
      default: op_o = VSSE;
    endcase
  end

  // Base address always comes from rs1
  assign illegal_o = !width_ok || !mop_ok || !rs1_valid_i;

endmodule

`default_nettype wire

// ==== spatz_arith_decoder.sv ====
/*
 * Integer vector arithmetic decoding for the vv, vx and vi forms.
 * Combinational, selected by the top for OP-V outside the config space.
 */
`timescale 1ns/1ps
`default_nettype none

`include "spatz_dec_macros.svh"

module spatz_arith_decoder (
  input  spatz_dec_pkg::instr_u instr_i,
  input  spatz_dec_pkg::elen_t  rs1_i,
  input  logic                  rs1_valid_i,
  output spatz_dec_pkg::op_e    op_o,
  output logic [4:0]            vd_o,
  output logic [4:0]            vs1_o,
  output logic [4:0]            vs2_o,
  output logic                  use_vs1_o,
  output logic                  vm_o,
  output spatz_dec_pkg::elen_t  rs1_o,
  output logic                  illegal_o
);

  import spatz_dec_pkg::*;

  logic [2:0] funct3;
  logic       is_vv;
  logic       is_vi;
  logic       is_opi;
  logic       no_imm;
  logic       form_ok;
  logic       op_ok;

  assign funct3 = instr_i.arith.funct3;
  assign vd_o   = instr_i.arith.vd;
  assign vs2_o  = instr_i.arith.vs2;
  assign vm_o   = instr_i.arith.vm;

  ////////////////////////////////////////////////////////////
  // Operand form
  ////////////////////////////////////////////////////////////

  always_comb begin
    use_vs1_o = 1'b0;
    vs1_o     = '0;
    rs1_o     = '0;
    form_ok   = 1'b1;
    unique case (funct3)
      `F3_OPIVV, `F3_OPMVV: begin
        use_vs1_o = 1'b1;
        vs1_o     = instr_i.arith.vs1;
      end
      `F3_OPIVI: rs1_o = {{(`ELEN-5){instr_i.arith.vs1[4]}}, instr_i.arith.vs1};
      `F3_OPIVX, `F3_OPMVX: begin
        rs1_o   = rs1_i;
        form_ok = rs1_valid_i;
      end
      default: form_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Operation
  ////////////////////////////////////////////////////////////

  // Kept operations live in the OPI space only
  assign is_vv  = funct3 == `F3_OPIVV;
  assign is_vi  = funct3 == `F3_OPIVI;
  assign is_opi = is_vv || is_vi || (funct3 == `F3_OPIVX);
  assign no_imm = is_opi && !is_vi;

  always_comb begin
    op_o  = NOP;
    op_ok = is_opi;
    unique case (instr_i.arith.funct6)
      6'b000000: op_o = VADD;
      6'b000010: begin
        op_o  = VSUB;
        op_ok = no_imm;
      end
      6'b000011: begin
        op_o  = VRSUB;
        op_ok = is_opi && !is_vv;
      end
      6'b000100: begin
        op_o  = VMINU;
        op_ok = no_imm;
      end
      6'b000101: begin
        op_o  = VMIN;
        op_ok = no_imm;
      end
      6'b000110: begin
        op_o  = VMAXU;
        op_ok = no_imm;
      end
      6'b000111: begin
        op_o  = VMAX;
        op_ok = no_imm;
      end
      6'b001001: op_o = VAND;
      6'b001010: op_o = VOR;
      6'b001011: op_o = VXOR;
      6'b100101: op_o = VSLL;
      6'b101000: op_o = VSRL;
      6'b101001: op_o = VSRA;
      default:   op_ok = 1'b0;
    endcase
  end

  assign illegal_o = !form_ok || !op_ok;

endmodule

`default_nettype wire

// ==== spatz_ctrl_decoder.sv ====
/*
 * Decoding of vsetvli, vsetivli, vsetvl and of accesses to the vector CSRs.
 * Combinational; opcode bit 5 separates the SYSTEM opcode from OP-V config.
 */
`timescale 1ns/1ps
`default_nettype none

`include "spatz_dec_macros.svh"

module spatz_ctrl_decoder (
  input  spatz_dec_pkg::instr_u instr_i,
  input  spatz_dec_pkg::elen_t  rs1_i,
  input  spatz_dec_pkg::elen_t  rs2_i,
  input  logic                  rs1_valid_i,
  input  logic                  rs2_valid_i,
  output spatz_dec_pkg::op_e    op_o,
  output logic [4:0]            rd_o,
  output spatz_dec_pkg::vtype_t vtype_o,
  output spatz_dec_pkg::elen_t  rs1_o,
  output logic                  keep_vl_o,
  output logic                  write_vstart_o,
  output logic                  set_vstart_o,
  output logic                  clear_vstart_o,
  output logic [11:0]           csr_addr_o,
  output logic                  is_csr_o,
  output logic                  illegal_o
);

  import spatz_dec_pkg::*;

  logic [11:0] addr;
  logic [7:0]  vtype_imm;
  logic [4:0]  avl_field;
  logic [4:0]  cfg_rd;
  logic        is_imm;
  logic        is_vstart;
  logic        field_nz;

  assign is_csr_o  = instr_i.mem.opcode[5];
  // CSR number sits in the upper 12 bits
  assign addr      = {instr_i.mem.nf, instr_i.mem.mew, instr_i.mem.mop,
                      instr_i.mem.vm, instr_i.mem.lumop};
  assign is_imm    = instr_i.mem.width[2];
  assign is_vstart = addr == `CSR_VSTART;
  assign field_nz  = instr_i.mem.rs1 != 5'd0;
  assign vtype_imm = {instr_i.arith.funct6[1:0], instr_i.arith.vm, instr_i.arith.vs2};
  assign avl_field = instr_i.arith.vs1;
  assign cfg_rd    = instr_i.arith.vd;

  always_comb begin
    op_o           = NOP;
    rd_o           = '0;
    vtype_o        = '0;
    rs1_o          = '0;
    keep_vl_o      = 1'b0;
    write_vstart_o = 1'b0;
    set_vstart_o   = 1'b0;
    clear_vstart_o = 1'b0;
    csr_addr_o     = '0;
    illegal_o      = 1'b0;
    if (is_csr_o) begin
      op_o      = VCSR;
      rd_o      = instr_i.mem.rd;
      rs1_o     = is_imm ? elen_t'(instr_i.mem.rs1) : rs1_i;
      illegal_o = !is_imm && !rs1_valid_i;
      case (addr)
        `CSR_VSTART, `CSR_VL, `CSR_VTYPE, `CSR_VLENB,
        `CSR_VXSAT, `CSR_VXRM, `CSR_VCSR: csr_addr_o = addr;
        default: illegal_o = 1'b1;
      endcase
      // rw, rs, rc; the rest of SYSTEM is not ours
      unique case (instr_i.mem.width[1:0])
        2'b01:   write_vstart_o = is_vstart;
        2'b10:   set_vstart_o = is_vstart && field_nz;
        2'b11:   clear_vstart_o = is_vstart && field_nz;
        default: illegal_o = 1'b1;
      endcase
    end else begin
      op_o = VCFG;
      rd_o = cfg_rd;
      if (!instr_i.arith.funct6[5]) begin
        vtype_o   = {1'b0, vtype_imm};
        rs1_o     = rs1_i;
        illegal_o = !rs1_valid_i;
      end else if (instr_i.arith.funct6[5:4] == 2'b11) begin
        vtype_o = {1'b0, vtype_imm};
        rs1_o   = elen_t'(avl_field);
      end else if ({instr_i.arith.funct6, instr_i.arith.vm} == 7'b1000000) begin
        vtype_o   = {1'b0, rs2_i[7:0]};
        rs1_o     = rs1_i;
        illegal_o = !rs1_valid_i || !rs2_valid_i;
      end else begin
        illegal_o = 1'b1;
      end
      // Request vlmax
      if (avl_field == 5'd0 && cfg_rd != 5'd0) begin
        rs1_o = '1;
      end
      keep_vl_o = avl_field == 5'd0 && cfg_rd == 5'd0;
    end
  end

endmodule

`default_nettype wire

// ==== spatz_decoder.sv ====
/*
 * Top of the vector instruction decoder. Routes the word by opcode to the
 * memory, arithmetic or control decoder and registers the merged response,
 * which appears one cycle after the request.
 */
`timescale 1ns/1ps
`default_nettype none

`include "spatz_dec_macros.svh"

module spatz_decoder (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  input  logic [31:0]             instr_i,
  input  spatz_dec_pkg::elen_t    rs1_i,
  input  logic                    rs1_valid_i,
  input  spatz_dec_pkg::elen_t    rs2_i,
  input  logic                    rs2_valid_i,
  output logic                    rsp_valid_o,
  output logic                    illegal_o,
  output spatz_dec_pkg::op_e      op_o,
  output spatz_dec_pkg::ex_unit_e ex_unit_o,
  output logic [4:0]              vd_o,
  output logic [4:0]              vs1_o,
  output logic [4:0]              vs2_o,
  output logic [4:0]              rd_o,
  output logic                    use_vd_o,
  output logic                    use_vs1_o,
  output logic                    use_vs2_o,
  output logic                    use_rd_o,
  output logic                    vd_is_src_o,
  output logic                    vm_o,
  output spatz_dec_pkg::elen_t    rs1_o,
  output spatz_dec_pkg::elen_t    rs2_o,
  output spatz_dec_pkg::vtype_t   vtype_o,
  output logic                    keep_vl_o,
  output logic                    write_vstart_o,
  output logic                    set_vstart_o,
  output logic                    clear_vstart_o,
  output logic                    reset_vstart_o,
  output logic [11:0]             csr_addr_o
);

  import spatz_dec_pkg::*;

  logic       sel_mem;
  logic       sel_arith;
  logic       sel_ctrl;
  op_e        m_op, a_op, c_op, nxt_op;
  vew_e       m_vsew;
  logic [4:0] m_vd, a_vd, a_vs1, a_vs2, c_rd;
  logic       m_use_vd, m_vd_is_src, m_vm, m_illegal;
  logic       a_use_vs1, a_vm, a_illegal;
  elen_t      m_rs1, m_rs2, a_rs1, c_rs1;
  vtype_t     c_vtype, nxt_vtype;
  logic       c_keep_vl, c_write_vstart, c_set_vstart, c_clear_vstart;
  logic       c_is_csr, c_illegal;
  logic [11:0] c_csr_addr, nxt_csr_addr;
  ex_unit_e   nxt_unit;
  logic [4:0] nxt_vd, nxt_vs1, nxt_vs2, nxt_rd;
  elen_t      nxt_rs1, nxt_rs2;
  logic       nxt_illegal, nxt_use_vd, nxt_use_vs1, nxt_use_vs2, nxt_use_rd;
  logic       nxt_vd_is_src, nxt_vm, nxt_keep_vl;
  logic       nxt_write_vstart, nxt_set_vstart, nxt_clear_vstart, nxt_reset_vstart;

  ////////////////////////////////////////////////////////////
  // Routing
  ////////////////////////////////////////////////////////////

  assign sel_mem   = (instr_i[6:0] == `OPC_LOAD_FP) || (instr_i[6:0] == `OPC_STORE_FP);
  assign sel_ctrl  = ((instr_i[6:0] == `OPC_VEC) && (instr_i[14:12] == `F3_OPCFG))
                     || (instr_i[6:0] == `OPC_SYSTEM);
  assign sel_arith = (instr_i[6:0] == `OPC_VEC) && (instr_i[14:12] != `F3_OPCFG);

  spatz_mem_decoder mem_dec_inst (
    .instr_i(instr_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rs1_valid_i(rs1_valid_i),
    .op_o(m_op), .vsew_o(m_vsew), .vd_o(m_vd), .use_vd_o(m_use_vd),
    .vd_is_src_o(m_vd_is_src), .vm_o(m_vm), .rs1_o(m_rs1), .rs2_o(m_rs2),
    .illegal_o(m_illegal)
  );

  spatz_arith_decoder arith_dec_inst (
    .instr_i(instr_i), .rs1_i(rs1_i), .rs1_valid_i(rs1_valid_i),
    .op_o(a_op), .vd_o(a_vd), .vs1_o(a_vs1), .vs2_o(a_vs2), .use_vs1_o(a_use_vs1),
    .vm_o(a_vm), .rs1_o(a_rs1), .illegal_o(a_illegal)
  );

  spatz_ctrl_decoder ctrl_dec_inst (
    .instr_i(instr_i), .rs1_i(rs1_i), .rs2_i(rs2_i),
    .rs1_valid_i(rs1_valid_i), .rs2_valid_i(rs2_valid_i),
    .op_o(c_op), .rd_o(c_rd), .vtype_o(c_vtype), .rs1_o(c_rs1), .keep_vl_o(c_keep_vl),
    .write_vstart_o(c_write_vstart), .set_vstart_o(c_set_vstart),
    .clear_vstart_o(c_clear_vstart), .csr_addr_o(c_csr_addr), .is_csr_o(c_is_csr),
    .illegal_o(c_illegal)
  );

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    nxt_op = NOP;
    nxt_unit = CON;
    nxt_vd = '0;
    nxt_vs1 = '0;
    nxt_vs2 = '0;
    nxt_rd = '0;
    nxt_rs1 = '0;
    nxt_rs2 = '0;
    nxt_vtype = '0;
    nxt_csr_addr = '0;
    nxt_illegal = 1'b0;
    nxt_use_vd = 1'b0;
    nxt_use_vs1 = 1'b0;
    nxt_use_vs2 = 1'b0;
    nxt_use_rd = 1'b0;
    nxt_vd_is_src = 1'b0;
    nxt_vm = 1'b0;
    nxt_keep_vl = 1'b0;
    nxt_write_vstart = 1'b0;
    nxt_set_vstart = 1'b0;
    nxt_clear_vstart = 1'b0;
    nxt_reset_vstart = 1'b0;
    if (req_valid_i) begin
      // Unknown opcode unless a decoder claims it
      nxt_illegal = 1'b1;
      if (sel_mem) begin
        nxt_op = m_op;
        nxt_unit = LSU;
        nxt_vd = m_vd;
        nxt_use_vd = m_use_vd;
        nxt_vd_is_src = m_vd_is_src;
        nxt_vm = m_vm;
        nxt_rs1 = m_rs1;
        nxt_rs2 = m_rs2;
        nxt_vtype.vsew = {1'b0, m_vsew};
        nxt_illegal = m_illegal;
      end else if (sel_arith) begin
        nxt_op = a_op;
        nxt_unit = VFU;
        nxt_vd = a_vd;
        nxt_vs1 = a_vs1;
        nxt_vs2 = a_vs2;
        nxt_use_vd = 1'b1;
        nxt_use_vs1 = a_use_vs1;
        nxt_use_vs2 = 1'b1;
        nxt_vm = a_vm;
        nxt_rs1 = a_rs1;
        nxt_illegal = a_illegal;
      end else if (sel_ctrl) begin
        nxt_op = c_op;
        nxt_unit = CON;
        nxt_rd = c_rd;
        // vstart write to x0 has no scalar result
        nxt_use_rd = !(c_write_vstart && c_rd == 5'd0);
        nxt_vtype = c_vtype;
        nxt_rs1 = c_rs1;
        nxt_keep_vl = c_keep_vl;
        nxt_write_vstart = c_write_vstart && !c_illegal;
        nxt_set_vstart = c_set_vstart && !c_illegal;
        nxt_clear_vstart = c_clear_vstart && !c_illegal;
        nxt_csr_addr = c_csr_addr;
        nxt_illegal = c_illegal;
      end
      nxt_reset_vstart = !nxt_illegal && !(sel_ctrl && c_is_csr);
    end
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      illegal_o <= 1'b0;
      use_vd_o <= 1'b0;
      use_vs1_o <= 1'b0;
      use_vs2_o <= 1'b0;
      use_rd_o <= 1'b0;
      vd_is_src_o <= 1'b0;
      vm_o <= 1'b0;
      keep_vl_o <= 1'b0;
      write_vstart_o <= 1'b0;
      set_vstart_o <= 1'b0;
      clear_vstart_o <= 1'b0;
      reset_vstart_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
      illegal_o <= nxt_illegal;
      use_vd_o <= nxt_use_vd;
      use_vs1_o <= nxt_use_vs1;
      use_vs2_o <= nxt_use_vs2;
      use_rd_o <= nxt_use_rd;
      vd_is_src_o <= nxt_vd_is_src;
      vm_o <= nxt_vm;
      keep_vl_o <= nxt_keep_vl;
      write_vstart_o <= nxt_write_vstart;
      set_vstart_o <= nxt_set_vstart;
      clear_vstart_o <= nxt_clear_vstart;
      reset_vstart_o <= nxt_reset_vstart;
    end
  end

  // Payload is already zero in idle cycles
  always_ff @(posedge clk_i) begin
    op_o <= nxt_op;
    ex_unit_o <= nxt_unit;
    vd_o <= nxt_vd;
    vs1_o <= nxt_vs1;
    vs2_o <= nxt_vs2;
    rd_o <= nxt_rd;
    rs1_o <= nxt_rs1;
    rs2_o <= nxt_rs2;
    vtype_o <= nxt_vtype;
    csr_addr_o <= nxt_csr_addr;
  end

endmodule

`default_nettype wire

// ==== spatz_decoder_props.sv ====
/*
 * Concurrent checks on the decoder response, bound into the top level.
 * They cover response timing and the illegal and vstart flags.
 */
`timescale 1ns/1ps
`default_nettype none

module spatz_decoder_props (
  input logic clk_i,
  input logic rst_i,
  input logic req_valid_i,
  input logic rsp_valid_i,
  input logic illegal_i,
  input logic write_vstart_i,
  input logic set_vstart_i,
  input logic clear_vstart_i,
  input logic reset_vstart_i
);

  // Exactly one cycle from request to response
  valid_latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> rsp_valid_i == $past(req_valid_i))
    else $error("rsp_valid_o does not follow req_valid_i by one cycle");

  illegal_needs_valid_a: assert property (@(posedge clk_i) disable iff (rst_i)
    illegal_i |-> rsp_valid_i)
    else $error("illegal_o raised without rsp_valid_o");

  illegal_no_vstart_a: assert property (@(posedge clk_i) disable iff (rst_i)
    illegal_i |-> !(write_vstart_i || set_vstart_i || clear_vstart_i || reset_vstart_i))
    else $error("vstart flag raised on an illegal response");

endmodule

bind spatz_decoder spatz_decoder_props spatz_decoder_props_inst (
  .clk_i(clk_i),
  .rst_i(rst_i),
  .req_valid_i(req_valid_i),
  .rsp_valid_i(rsp_valid_o),
  .illegal_i(illegal_o),
  .write_vstart_i(write_vstart_o),
  .set_vstart_i(set_vstart_o),
  .clear_vstart_i(clear_vstart_o),
  .reset_vstart_i(reset_vstart_o)
);

`default_nettype wire

// ==== tb_spatz_decoder.sv ====
/*
 * Testbench for the vector instruction decoder. Replays the golden vectors
 * with random idle gaps and checks each response in the cycle after its request.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_spatz_decoder;

  import spatz_dec_pkg::*;

  localparam int NUM_VEC     = 32;
  localparam int NUM_COL     = 12;
  localparam int CYCLE_LIMIT = 10 + 5 * NUM_VEC + 20;

  logic        clk_i;
  logic        rst_i;
  logic        req_valid_i;
  logic [31:0] instr_i;
  elen_t       rs1_i;
  logic        rs1_valid_i;
  elen_t       rs2_i;
  logic        rs2_valid_i;
  logic        rsp_valid_o;
  logic        illegal_o;
  op_e         op_o;
  ex_unit_e    ex_unit_o;
  logic [4:0]  vd_o;
  logic [4:0]  vs1_o;
  logic [4:0]  vs2_o;
  logic [4:0]  rd_o;
  logic        use_vd_o;
  logic        use_vs1_o;
  logic        use_vs2_o;
  logic        use_rd_o;
  logic        vd_is_src_o;
  logic        vm_o;
  elen_t       rs1_o;
  elen_t       rs2_o;
  vtype_t      vtype_o;
  logic        keep_vl_o;
  logic        write_vstart_o;
  logic        set_vstart_o;
  logic        clear_vstart_o;
  logic        reset_vstart_o;
  logic [11:0] csr_addr_o;

  logic [31:0] golden [0:NUM_VEC*NUM_COL-1];
  logic [31:0] rand_state;
  int          cycle_count = 0;
  int          cur_vec = -1;

  spatz_decoder spatz_decoder_inst (
    .clk_i(clk_i), .rst_i(rst_i), .req_valid_i(req_valid_i), .instr_i(instr_i),
    .rs1_i(rs1_i), .rs1_valid_i(rs1_valid_i), .rs2_i(rs2_i), .rs2_valid_i(rs2_valid_i),
    .rsp_valid_o(rsp_valid_o), .illegal_o(illegal_o), .op_o(op_o), .ex_unit_o(ex_unit_o),
    .vd_o(vd_o), .vs1_o(vs1_o), .vs2_o(vs2_o), .rd_o(rd_o),
    .use_vd_o(use_vd_o), .use_vs1_o(use_vs1_o), .use_vs2_o(use_vs2_o),
    .use_rd_o(use_rd_o), .vd_is_src_o(vd_is_src_o), .vm_o(vm_o),
    .rs1_o(rs1_o), .rs2_o(rs2_o), .vtype_o(vtype_o), .keep_vl_o(keep_vl_o),
    .write_vstart_o(write_vstart_o), .set_vstart_o(set_vstart_o),
    .clear_vstart_o(clear_vstart_o), .reset_vstart_o(reset_vstart_o),
    .csr_addr_o(csr_addr_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the test did not end within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("Fail at time %0d ns: vector %0d, %s", $time, cur_vec, msg);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_op(input op_e got, input op_e exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
  endtask

  task automatic check_unit(input ex_unit_e got, input ex_unit_e exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
  endtask

  task automatic check_vtype(input vtype_t got, input vtype_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_word(input elen_t got, input elen_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and response
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic apply_request(input int idx);
    int base;
    base = idx * NUM_COL;
    instr_i     = golden[base];
    rs1_i       = golden[base+1];
    rs1_valid_i = golden[base+2][0];
    rs2_i       = golden[base+3];
    rs2_valid_i = golden[base+4][0];
    req_valid_i = 1'b1;
  endtask

  task automatic clear_request();
    req_valid_i = 1'b0;
    instr_i     = '0;
    rs1_i       = '0;
    rs1_valid_i = 1'b0;
    rs2_i       = '0;
    rs2_valid_i = 1'b0;
  endtask

  task automatic check_idle();
    check_bit(rsp_valid_o, 1'b0, "rsp_valid_o in idle cycle");
    check_bit(illegal_o, 1'b0, "illegal_o in idle cycle");
    check_op(op_o, NOP, "op_o in idle cycle");
  endtask

  // Register fields follow from the instruction layout and the target unit
  task automatic check_operands(input int idx, input ex_unit_e unit, input op_e op,
                                input logic vs1_used);
    int          base;
    logic [31:0] instr;
    logic [4:0]  exp_vs1;
    logic [4:0]  exp_vs2;
    logic [4:0]  exp_rd;
    logic [11:0] exp_csr;
    logic        exp_use_vd;
    logic        exp_use_vs2;
    logic        exp_vm;
    elen_t       exp_rs2;
    base        = idx * NUM_COL;
    instr       = golden[base];
    exp_vs1     = '0;
    exp_vs2     = '0;
    exp_rd      = '0;
    exp_csr     = '0;
    exp_use_vd  = 1'b0;
    exp_use_vs2 = 1'b0;
    exp_vm      = 1'b0;
    exp_rs2     = '0;
    if (unit == LSU) begin
      exp_use_vd = 1'b1;
      exp_vm     = instr[25];
      if (op == VLSE || op == VSSE)
        exp_rs2 = golden[base+3];
    end else if (unit == VFU) begin
      exp_use_vd  = 1'b1;
      exp_use_vs2 = 1'b1;
      exp_vm      = instr[25];
      exp_vs2     = instr[24:20];
      if (vs1_used)
        exp_vs1 = instr[19:15];
    end else begin
      exp_rd = instr[11:7];
      if (op == VCSR)
        exp_csr = instr[31:20];
    end
    check_word({27'd0, vs1_o}, {27'd0, exp_vs1}, "vs1_o");
    check_word({27'd0, vs2_o}, {27'd0, exp_vs2}, "vs2_o");
    check_word({27'd0, rd_o}, {27'd0, exp_rd}, "rd_o");
    check_word({20'd0, csr_addr_o}, {20'd0, exp_csr}, "csr_addr_o");
    check_word(rs2_o, exp_rs2, "rs2_o");
    check_bit(use_vd_o, exp_use_vd, "use_vd_o");
    check_bit(use_vs2_o, exp_use_vs2, "use_vs2_o");
    check_bit(vm_o, exp_vm, "vm_o");
  endtask

  // Fields of an illegal response are don't care, the flags are not
  task automatic check_response(input int idx);
    int         base;
    logic       exp_illegal;
    logic [7:0] flags;
    base        = idx * NUM_COL;
    exp_illegal = golden[base+5][0];
    flags       = golden[base+11][7:0];
    check_bit(rsp_valid_o, 1'b1, "rsp_valid_o");
    check_bit(illegal_o, exp_illegal, "illegal_o");
    check_bit(write_vstart_o, flags[5], "write_vstart_o");
    check_bit(set_vstart_o, flags[4], "set_vstart_o");
    check_bit(clear_vstart_o, flags[3], "clear_vstart_o");
    check_bit(reset_vstart_o, flags[2], "reset_vstart_o");
    if (!exp_illegal) begin
      check_op(op_o, op_e'(golden[base+6][4:0]), "op_o");
      check_unit(ex_unit_o, ex_unit_e'(golden[base+7][1:0]), "ex_unit_o");
      check_word({27'd0, vd_o}, golden[base+8], "vd_o");
      check_word(rs1_o, golden[base+9], "rs1_o");
      check_vtype(vtype_o, vtype_t'(golden[base+10][8:0]), "vtype_o");
      check_bit(vd_is_src_o, flags[7], "vd_is_src_o");
      check_bit(keep_vl_o, flags[6], "keep_vl_o");
      check_bit(use_rd_o, flags[1], "use_rd_o");
      check_bit(use_vs1_o, flags[0], "use_vs1_o");
      check_operands(idx, ex_unit_e'(golden[base+7][1:0]), op_e'(golden[base+6][4:0]),
                     flags[0]);
    end
  endtask

  initial begin
    int i;
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    rand_state = 32'h2673;
    clear_request();
    $readmemh("decoder_golden.txt", golden);
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_idle();
    for (i = 0; i < NUM_VEC; i++) begin
      rand_state = xorshift32(rand_state);
      repeat (rand_state[1:0]) begin
        @(posedge clk_i);
        #1;
        check_idle();
      end
      cur_vec = i;
      apply_request(i);
      @(posedge clk_i);
      #1;
      clear_request();
      check_response(i);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== decoder_golden.txt ====
// instr rs1 rs1_valid rs2 rs2_valid | illegal op ex_unit vd rs1_o vtype flags
// flags: 7 vd_is_src, 6 keep_vl, 5 write_vs, 4 set_vs, 3 clear_vs, 2 reset_vs, 1 use_rd, 0 use_vs1
02050087 00001000 1 00000000 0 0 01 2 01 00001000 000 04
02055107 00002000 1 00000000 0 0 01 2 02 00002000 008 04
02056187 00003000 1 00000000 0 0 01 2 03 00003000 010 04
0AB50207 00004000 1 00000010 1 0 02 2 04 00004000 000 04
0AB56287 00005000 1 00000020 1 0 02 2 05 00005000 010 04
02050327 00006000 1 00000000 0 0 03 2 06 00006000 000 84
020553A7 00007000 1 00000000 0 0 03 2 07 00007000 008 84
0AB56427 00008000 1 00000040 1 0 04 2 08 00008000 010 84
02051487 00009000 1 00000000 0 1 00 0 00 00000000 000 00
022180D7 DEADBEEF 1 00000000 0 0 07 1 01 00000000 000 05
0222C257 12345678 1 00000000 0 0 07 1 04 12345678 000 04
022832D7 00000000 0 00000000 0 0 07 1 05 FFFFFFF0 000 04
0E234357 00000007 1 00000000 0 0 09 1 06 00000007 000 04
0E22B3D7 00000000 0 00000000 0 0 09 1 07 00000005 000 04
2E218457 00000000 0 00000000 0 0 0C 1 08 00000000 000 05
2E27B4D7 00000000 0 00000000 0 0 0C 1 09 0000000F 000 04
A623C557 00000003 1 00000000 0 0 0F 1 0A 00000003 000 04
A62FB5D7 00000000 0 00000000 0 0 0F 1 0B FFFFFFFF 000 04
1A218657 00000000 0 00000000 0 0 13 1 0C 00000000 000 05
1A2446D7 0000FFFF 1 00000000 0 0 13 1 0D 0000FFFF 000 04
322180D7 00000000 0 00000000 0 1 00 0 00 00000000 000 00
0222C257 12345678 0 00000000 0 1 00 0 00 00000000 000 00
010072D7 00000000 1 00000000 0 0 05 0 00 FFFFFFFF 010 06
00907057 00000000 1 00000000 0 0 05 0 00 00000000 009 46
C4067357 00000000 0 00000000 0 0 05 0 00 0000000C 040 06
80B573D7 00000040 1 ABCD00D2 1 0 05 0 00 00000040 0D2 06
00829073 00000003 1 00000000 0 0 06 0 00 00000003 000 20
008062F3 00000000 0 00000000 0 0 06 0 00 00000000 000 02
008330F3 00000004 1 00000000 0 0 06 0 00 00000004 000 0A
300022F3 00000000 1 00000000 0 1 00 0 00 00000000 000 00
00000013 00000000 1 00000000 0 1 00 0 00 00000000 000 00
C2002473 00000000 1 00000000 0 0 06 0 00 00000000 000 02

// ==== all.f ====
+incdir+.
spatz_dec_pkg.sv
spatz_mem_decoder.sv
spatz_arith_decoder.sv
spatz_ctrl_decoder.sv
spatz_decoder.sv
spatz_decoder_props.sv
tb_spatz_decoder.sv

// ==== Makefile ====
TOP = tb_spatz_decoder

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
